//--- common/meta_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, depths and channel types of the ID remapper
// FIXED_OUT_ID must stay at or above ATOP_SLOTS
// SLOT_W and the pointer widths must match the depths by hand
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package meta_pkg;

  localparam int unsigned IN_ID_W    = 4;
  localparam int unsigned OUT_ID_W   = 3;
  localparam int unsigned NODE_W     = 4;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned TXN_DEPTH  = 4;
  localparam int unsigned TXN_PTR_W  = 2;
  localparam int unsigned TXN_CNT_W  = 3;
  localparam int unsigned ATOP_SLOTS = 2;
  localparam int unsigned SLOT_W     = 1;

  // Ordinary traffic shares the top ID, atomics use IDs 0 .. ATOP_SLOTS-1
  localparam logic [OUT_ID_W-1:0] FIXED_OUT_ID = '1;

  typedef logic [IN_ID_W-1:0]  in_id_t;
  typedef logic [OUT_ID_W-1:0] out_id_t;
  typedef logic [NODE_W-1:0]   node_t;
  typedef logic [SLOT_W-1:0]   slot_t;
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;

  typedef struct packed {in_id_t id; addr_t addr; logic atop; logic atop_r;} in_aw_t;
  typedef struct packed {in_id_t id; addr_t addr;} in_ar_t;
  typedef struct packed {in_id_t id; data_t data; logic last;} in_r_t;
  typedef struct packed {in_id_t id;} in_b_t;

  typedef struct packed {out_id_t id; addr_t addr; logic atop; logic atop_r;} out_aw_t;
  typedef struct packed {out_id_t id; addr_t addr;} out_ar_t;
  typedef struct packed {out_id_t id; data_t data; logic last;} out_r_t;
  typedef struct packed {out_id_t id;} out_b_t;

  // Kept per outstanding read
  typedef struct packed {
    in_id_t id;
    node_t  node;
  } rd_meta_t;

  // Kept per outstanding write, has_r marks an atomic that also returns R data
  typedef struct packed {
    in_id_t id;
    node_t  node;
    logic   has_r;
  } wr_meta_t;

endpackage

//--- files.f
common/meta_pkg.sv
meta_buffer/meta_fifo.sv
meta_buffer/atop_slots.sv
meta_buffer/meta_ctrl.sv
meta_buffer/meta_buffer_top.sv
sim/tb_meta_buffer.sv

//--- meta_buffer/atop_slots.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Atomic slot table with ATOP_SLOTS entries
// A slot is busy while its R or B pending flag is set
// Grant is the lowest free slot, combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module atop_slots import meta_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     claim_i,
  input  slot_t    claim_slot_i,
  input  wr_meta_t claim_meta_i,
  output slot_t    grant_slot_o,
  output logic     slot_free_o,
  input  logic     clr_b_i,
  input  slot_t    clr_b_slot_i,
  input  logic     clr_r_i,
  input  slot_t    clr_r_slot_i,
  output wr_meta_t b_meta_o,
  input  slot_t    b_slot_i,
  output wr_meta_t r_meta_o,
  input  slot_t    r_slot_i
);

  wr_meta_t meta_q [ATOP_SLOTS];

  logic [ATOP_SLOTS-1:0] b_pend_q, r_pend_q;
  logic [ATOP_SLOTS-1:0] free;

  assign free        = ~(b_pend_q | r_pend_q);
  assign slot_free_o = |free;

  // Walk down so the lowest free index wins
  always_comb begin
    grant_slot_o = '0;
    for (int i = ATOP_SLOTS - 1; i >= 0; i--) begin
      if (free[i]) grant_slot_o = slot_t'(i);
    end
  end

  assign b_meta_o = meta_q[b_slot_i];
  assign r_meta_o = meta_q[r_slot_i];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_pend_q <= '0;
      r_pend_q <= '0;
    end else begin
      if (clr_b_i) b_pend_q[clr_b_slot_i] <= 1'b0;
      if (clr_r_i) r_pend_q[clr_r_slot_i] <= 1'b0;
      // Claim targets a free slot, so it never collides with a clear
      if (claim_i) begin
        b_pend_q[claim_slot_i] <= 1'b1;
        r_pend_q[claim_slot_i] <= claim_meta_i.has_r;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (claim_i) meta_q[claim_slot_i] <= claim_meta_i;
  end

  claim_free_slot: assert property (@(posedge clk_i) disable iff (reset_i)
    claim_i |-> free[claim_slot_i]);

  // A released atomic response must belong to a slot that still waits for it
  b_clear_pending: assert property (@(posedge clk_i) disable iff (reset_i)
    clr_b_i |-> b_pend_q[clr_b_slot_i]);
  r_clear_pending: assert property (@(posedge clk_i) disable iff (reset_i)
    clr_r_i |-> r_pend_q[clr_r_slot_i]);

endmodule

//--- meta_buffer/meta_buffer_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ID remapping and metadata buffer top level
// Up to TXN_DEPTH reads, TXN_DEPTH writes and ATOP_SLOTS atomics
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module meta_buffer_top import meta_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,
  input  in_aw_t  aw_i,
  input  logic    aw_valid_i,
  output logic    aw_ready_o,
  input  node_t   aw_node_i,
  input  in_ar_t  ar_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  input  node_t   ar_node_i,
  output in_b_t   b_o,
  output logic    b_valid_o,
  input  logic    b_ready_i,
  output node_t   b_node_o,
  output in_r_t   r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i,
  output node_t   r_node_o,
  output out_aw_t aw_dn_o,
  output logic    aw_dn_valid_o,
  input  logic    aw_dn_ready_i,
  output out_ar_t ar_dn_o,
  output logic    ar_dn_valid_o,
  input  logic    ar_dn_ready_i,
  input  out_b_t  b_dn_i,
  input  logic    b_dn_valid_i,
  output logic    b_dn_ready_o,
  input  out_r_t  r_dn_i,
  input  logic    r_dn_valid_i,
  output logic    r_dn_ready_o
);

  logic     rd_push, rd_pop, rd_full, rd_empty;
  logic     wr_push, wr_pop, wr_full, wr_empty;
  rd_meta_t rd_meta, rd_head;
  wr_meta_t wr_meta, wr_head;

  logic     claim, slot_free, clr_b, clr_r;
  slot_t    claim_slot, grant_slot, clr_b_slot, clr_r_slot, b_slot, r_slot;
  wr_meta_t claim_meta, b_meta, r_meta;

  // Channel ports connect by name
  meta_ctrl meta_ctrl_inst (
    .*,
    .rd_push_o    (rd_push),
    .rd_meta_o    (rd_meta),
    .rd_pop_o     (rd_pop),
    .rd_head_i    (rd_head),
    .rd_full_i    (rd_full),
    .rd_empty_i   (rd_empty),
    .wr_push_o    (wr_push),
    .wr_meta_o    (wr_meta),
    .wr_pop_o     (wr_pop),
    .wr_head_i    (wr_head),
    .wr_full_i    (wr_full),
    .wr_empty_i   (wr_empty),
    .claim_o      (claim),
    .claim_slot_o (claim_slot),
    .claim_meta_o (claim_meta),
    .grant_slot_i (grant_slot),
    .slot_free_i  (slot_free),
    .clr_b_o      (clr_b),
    .clr_b_slot_o (clr_b_slot),
    .clr_r_o      (clr_r),
    .clr_r_slot_o (clr_r_slot),
    .b_meta_i     (b_meta),
    .b_slot_o     (b_slot),
    .r_meta_i     (r_meta),
    .r_slot_o     (r_slot)
  );

  meta_fifo #(.payload_t(rd_meta_t)) rd_fifo_inst (
    .clk_i,
    .reset_i,
    .push_i  (rd_push),
    .data_i  (rd_meta),
    .pop_i   (rd_pop),
    .data_o  (rd_head),
    .full_o  (rd_full),
    .empty_o (rd_empty)
  );

  meta_fifo #(.payload_t(wr_meta_t)) wr_fifo_inst (
    .clk_i,
    .reset_i,
    .push_i  (wr_push),
    .data_i  (wr_meta),
    .pop_i   (wr_pop),
    .data_o  (wr_head),
    .full_o  (wr_full),
    .empty_o (wr_empty)
  );

  atop_slots atop_slots_inst (
    .clk_i,
    .reset_i,
    .claim_i      (claim),
    .claim_slot_i (claim_slot),
    .claim_meta_i (claim_meta),
    .grant_slot_o (grant_slot),
    .slot_free_o  (slot_free),
    .clr_b_i      (clr_b),
    .clr_b_slot_i (clr_b_slot),
    .clr_r_i      (clr_r),
    .clr_r_slot_i (clr_r_slot),
    .b_meta_o     (b_meta),
    .b_slot_i     (b_slot),
    .r_meta_o     (r_meta),
    .r_slot_i     (r_slot)
  );

endmodule

//--- meta_buffer/meta_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ID remap and metadata control, all channels pass through
// Ordinary requests leave on FIXED_OUT_ID, atomics on a slot ID
// Responses with ID below ATOP_SLOTS are treated as atomic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module meta_ctrl import meta_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  // Upstream
  input  in_aw_t   aw_i,
  input  logic     aw_valid_i,
  output logic     aw_ready_o,
  input  node_t    aw_node_i,
  input  in_ar_t   ar_i,
  input  logic     ar_valid_i,
  output logic     ar_ready_o,
  input  node_t    ar_node_i,
  output in_b_t    b_o,
  output logic     b_valid_o,
  input  logic     b_ready_i,
  output node_t    b_node_o,
  output in_r_t    r_o,
  output logic     r_valid_o,
  input  logic     r_ready_i,
  output node_t    r_node_o,
  // Downstream
  output out_aw_t  aw_dn_o,
  output logic     aw_dn_valid_o,
  input  logic     aw_dn_ready_i,
  output out_ar_t  ar_dn_o,
  output logic     ar_dn_valid_o,
  input  logic     ar_dn_ready_i,
  input  out_b_t   b_dn_i,
  input  logic     b_dn_valid_i,
  output logic     b_dn_ready_o,
  input  out_r_t   r_dn_i,
  input  logic     r_dn_valid_i,
  output logic     r_dn_ready_o,
  // Read and write FIFOs
  output logic     rd_push_o,
  output rd_meta_t rd_meta_o,
  output logic     rd_pop_o,
  input  rd_meta_t rd_head_i,
  input  logic     rd_full_i,
  input  logic     rd_empty_i,
  output logic     wr_push_o,
  output wr_meta_t wr_meta_o,
  output logic     wr_pop_o,
  input  wr_meta_t wr_head_i,
  input  logic     wr_full_i,
  input  logic     wr_empty_i,
  // Atomic slot table
  output logic     claim_o,
  output slot_t    claim_slot_o,
  output wr_meta_t claim_meta_o,
  input  slot_t    grant_slot_i,
  input  logic     slot_free_i,
  output logic     clr_b_o,
  output slot_t    clr_b_slot_o,
  output logic     clr_r_o,
  output slot_t    clr_r_slot_o,
  input  wr_meta_t b_meta_i,
  output slot_t    b_slot_o,
  input  wr_meta_t r_meta_i,
  output slot_t    r_slot_o
);

  logic  is_atop_aw, aw_admit, aw_xfer, ar_xfer, b_xfer, r_xfer;
  logic  is_atop_b, is_atop_r;
  logic  pending_q, pending_d;
  slot_t held_slot_q, aw_slot;

  // Request side
  assign is_atop_aw = aw_i.atop;
  assign aw_admit   = is_atop_aw ? slot_free_i : !wr_full_i;

  assign aw_dn_valid_o = aw_valid_i && aw_admit;
  assign aw_ready_o    = aw_dn_ready_i && aw_admit;
  assign ar_dn_valid_o = ar_valid_i && !rd_full_i;
  assign ar_ready_o    = ar_dn_ready_i && !rd_full_i;

  assign aw_xfer = aw_dn_valid_o && aw_dn_ready_i;
  assign ar_xfer = ar_dn_valid_o && ar_dn_ready_i;

  // A stalled atomic keeps the slot it saw first
  assign pending_d = is_atop_aw && aw_dn_valid_o && !aw_dn_ready_i;
  assign aw_slot   = pending_q ? held_slot_q : grant_slot_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q   <= 1'b0;
      held_slot_q <= '0;
    end else begin
      pending_q <= pending_d;
      if (!pending_q) held_slot_q <= grant_slot_i;
    end
  end

  always_comb begin
    aw_dn_o = '{id: is_atop_aw ? out_id_t'(aw_slot) : FIXED_OUT_ID, addr: aw_i.addr,
                atop: aw_i.atop, atop_r: aw_i.atop_r};
    ar_dn_o = '{id: FIXED_OUT_ID, addr: ar_i.addr};
  end

  assign rd_meta_o    = '{id: ar_i.id, node: ar_node_i};
  assign wr_meta_o    = '{id: aw_i.id, node: aw_node_i, has_r: aw_i.atop && aw_i.atop_r};
  assign claim_meta_o = wr_meta_o;
  assign claim_slot_o = aw_slot;

  assign rd_push_o = ar_xfer;
  assign wr_push_o = aw_xfer && !is_atop_aw;
  assign claim_o   = aw_xfer && is_atop_aw;

  // Response side
  assign is_atop_b = (b_dn_i.id < out_id_t'(ATOP_SLOTS));
  assign is_atop_r = (r_dn_i.id < out_id_t'(ATOP_SLOTS));
  assign b_slot_o  = b_dn_i.id[SLOT_W-1:0];
  assign r_slot_o  = r_dn_i.id[SLOT_W-1:0];

  assign b_valid_o    = b_dn_valid_i;
  assign b_dn_ready_o = b_ready_i;
  assign r_valid_o    = r_dn_valid_i;
  assign r_dn_ready_o = r_ready_i;

  assign b_o.id   = is_atop_b ? b_meta_i.id : wr_head_i.id;
  assign b_node_o = is_atop_b ? b_meta_i.node : wr_head_i.node;
  assign r_o.id   = is_atop_r ? r_meta_i.id : rd_head_i.id;
  assign r_o.data = r_dn_i.data;
  assign r_o.last = r_dn_i.last;
  assign r_node_o = is_atop_r ? r_meta_i.node : rd_head_i.node;

  assign b_xfer = b_valid_o && b_ready_i;
  assign r_xfer = r_valid_o && r_ready_i && r_dn_i.last;

  assign wr_pop_o     = b_xfer && !is_atop_b;
  assign rd_pop_o     = r_xfer && !is_atop_r;
  assign clr_b_o      = b_xfer && is_atop_b;
  assign clr_b_slot_o = b_slot_o;
  assign clr_r_o      = r_xfer && is_atop_r;
  assign clr_r_slot_o = r_slot_o;

  b_has_meta: assert property (@(posedge clk_i) disable iff (reset_i)
    (b_dn_valid_i && !is_atop_b) |-> !wr_empty_i);
  r_has_meta: assert property (@(posedge clk_i) disable iff (reset_i)
    (r_dn_valid_i && !is_atop_r) |-> !rd_empty_i);

endmodule

//--- meta_buffer/meta_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// In-order metadata FIFO of TXN_DEPTH entries
// Head entry is shown without a register, no flush
// Caller must not push when full nor pop when empty
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module meta_fifo import meta_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     full_o,
  output logic     empty_o
);

  payload_t mem_q [TXN_DEPTH];

  logic [TXN_PTR_W-1:0] rd_ptr_q, wr_ptr_q;
  logic [TXN_CNT_W-1:0] count_q;

  function automatic logic [TXN_PTR_W-1:0] next_ptr(input logic [TXN_PTR_W-1:0] ptr);
    return (ptr == TXN_PTR_W'(TXN_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == TXN_CNT_W'(TXN_DEPTH));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop_i)  rd_ptr_q <= next_ptr(rd_ptr_q);
      // Count only moves when exactly one side is active
      if (push_i && !pop_i)      count_q <= count_q + 1'b1;
      else if (pop_i && !push_i) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= data_i;
  end

  push_not_full: assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> !full_o);
  pop_not_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> !empty_o);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_meta_buffer -o tb_sim

# A fatal stop leaves no pass line in the log
./obj_dir/tb_sim | tee sim.log

if grep -qx "Test OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- sim/tb_meta_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the ID remapping metadata buffer
// Ready inputs stay high except in the stall and ready tests
// The tasks act as the downstream responder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_meta_buffer import meta_pkg::*; ();

  localparam int TIMEOUT = 50;

  logic    clk_i, reset_i;
  in_aw_t  aw_i;
  logic    aw_valid_i, aw_ready_o;
  node_t   aw_node_i;
  in_ar_t  ar_i;
  logic    ar_valid_i, ar_ready_o;
  node_t   ar_node_i;
  in_b_t   b_o;
  logic    b_valid_o, b_ready_i;
  node_t   b_node_o;
  in_r_t   r_o;
  logic    r_valid_o, r_ready_i;
  node_t   r_node_o;
  out_aw_t aw_dn_o;
  logic    aw_dn_valid_o, aw_dn_ready_i;
  out_ar_t ar_dn_o;
  logic    ar_dn_valid_o, ar_dn_ready_i;
  out_b_t  b_dn_i;
  logic    b_dn_valid_i, b_dn_ready_o;
  out_r_t  r_dn_i;
  logic    r_dn_valid_i, r_dn_ready_o;

  // Reference model of the outstanding metadata
  rd_meta_t              rd_exp_q[$];
  wr_meta_t              wr_exp_q[$];
  wr_meta_t              slot_meta [ATOP_SLOTS];
  logic [ATOP_SLOTS-1:0] slot_b_busy, slot_r_busy;
  out_id_t               last_aw_id;
  int                    seed = 32'h36e5;

  // Slot an atomic saw first while stalled downstream
  slot_t                 stall_slot;
  logic                  stall_held;

  meta_buffer_top meta_buffer_top_inst (.*);

  always #50 clk_i = ~clk_i;

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      fail_stop($sformatf("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp));
    end
  endtask

  // Channel select: 0 AW, 1 AR, 2 B, 3 R
  function automatic logic hs_done(input int chan);
    case (chan)
      0:       return aw_ready_o && aw_dn_valid_o;
      1:       return ar_ready_o && ar_dn_valid_o;
      2:       return b_valid_o && b_dn_ready_o;
      default: return r_valid_o && r_dn_ready_o;
    endcase
  endfunction

  task automatic wait_hs(input int chan, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!hs_done(chan)) begin
      cycles++;
      if (cycles > TIMEOUT) fail_stop($sformatf("Timeout waiting for %s", what));
      @(negedge clk_i);
    end
  endtask

  // Lowest slot with both pending flags clear
  function automatic slot_t lowest_free();
    slot_t s;
    logic  found;
    s = '0;
    found = 1'b0;
    for (int i = 0; i < ATOP_SLOTS; i++) begin
      if (!found && !slot_b_busy[i] && !slot_r_busy[i]) begin
        s = slot_t'(i);
        found = 1'b1;
      end
    end
    return s;
  endfunction

  task automatic start_aw(input logic atop, input logic atop_r);
    @(posedge clk_i);
    aw_i       <= '{id: in_id_t'($random(seed)), addr: addr_t'($random(seed)),
                    atop: atop, atop_r: atop_r};
    aw_node_i  <= node_t'($random(seed));
    aw_valid_i <= 1'b1;
  endtask

  task automatic finish_aw();
    slot_t    s;
    wr_meta_t meta;
    wait_hs(0, "AW ready");
    check_eq(aw_dn_o.addr, aw_i.addr, "AW address");
    check_eq(32'(aw_dn_o.atop), 32'(aw_i.atop), "AW atop flag");
    check_eq(32'(aw_dn_o.atop_r), 32'(aw_i.atop_r), "AW atop_r flag");
    meta = '{id: aw_i.id, node: aw_node_i, has_r: aw_i.atop && aw_i.atop_r};
    if (aw_i.atop) begin
      s = stall_held ? stall_slot : lowest_free();
      stall_held = 1'b0;
      check_eq(32'(aw_dn_o.id), 32'(s), "atomic AW downstream ID");
      slot_meta[s]   = meta;
      slot_b_busy[s] = 1'b1;
      slot_r_busy[s] = aw_i.atop_r;
    end else begin
      check_eq(32'(aw_dn_o.id), 32'(FIXED_OUT_ID), "ordinary AW downstream ID");
      wr_exp_q.push_back(meta);
    end
    last_aw_id = aw_dn_o.id;
    @(posedge clk_i);
    aw_valid_i <= 1'b0;
  endtask

  task automatic send_aw(input logic atop, input logic atop_r);
    start_aw(atop, atop_r);
    finish_aw();
  endtask

  task automatic check_aw_stalled();
    repeat (2) begin
      @(negedge clk_i);
      check_eq(32'(aw_ready_o), 32'd0, "AW ready during stall");
      check_eq(32'(aw_dn_valid_o), 32'd0, "AW downstream valid during stall");
    end
  endtask

  task automatic send_ar();
    @(posedge clk_i);
    ar_i       <= '{id: in_id_t'($random(seed)), addr: addr_t'($random(seed))};
    ar_node_i  <= node_t'($random(seed));
    ar_valid_i <= 1'b1;
    wait_hs(1, "AR ready");
    check_eq(32'(ar_dn_o.id), 32'(FIXED_OUT_ID), "AR downstream ID");
    check_eq(ar_dn_o.addr, ar_i.addr, "AR address");
    rd_exp_q.push_back(rd_meta_t'{id: ar_i.id, node: ar_node_i});
    @(posedge clk_i);
    ar_valid_i <= 1'b0;
  endtask

  task automatic send_b(input out_id_t dn_id);
    wr_meta_t exp;
    slot_t    s;
    s = slot_t'(dn_id);
    @(posedge clk_i);
    b_dn_i       <= '{id: dn_id};
    b_dn_valid_i <= 1'b1;
    wait_hs(2, "B valid");
    if (dn_id < out_id_t'(ATOP_SLOTS)) begin
      exp = slot_meta[s];
      slot_b_busy[s] = 1'b0;
    end else begin
      exp = wr_exp_q.pop_front();
    end
    check_eq(32'(b_o.id), 32'(exp.id), "B upstream ID");
    check_eq(32'(b_node_o), 32'(exp.node), "B node");
    @(posedge clk_i);
    b_dn_valid_i <= 1'b0;
  endtask

  task automatic send_r(input out_id_t dn_id, input logic last);
    rd_meta_t exp;
    slot_t    s;
    data_t    data;
    s = slot_t'(dn_id);
    data = data_t'($random(seed));
    @(posedge clk_i);
    r_dn_i       <= '{id: dn_id, data: data, last: last};
    r_dn_valid_i <= 1'b1;
    wait_hs(3, "R valid");
    if (dn_id < out_id_t'(ATOP_SLOTS)) begin
      exp = '{id: slot_meta[s].id, node: slot_meta[s].node};
      if (last) slot_r_busy[s] = 1'b0;
    end else begin
      exp = rd_exp_q[0];
      if (last) rd_exp_q.delete(0);
    end
    check_eq(32'(r_o.id), 32'(exp.id), "R upstream ID");
    check_eq(32'(r_node_o), 32'(exp.node), "R node");
    check_eq(r_o.data, data, "R data");
    check_eq(32'(r_o.last), 32'(last), "R last");
    @(posedge clk_i);
    r_dn_valid_i <= 1'b0;
  endtask

  task automatic test_read_remap();
    send_ar();
    send_r(FIXED_OUT_ID, 1'b0);
    send_r(FIXED_OUT_ID, 1'b1);
  endtask

  task automatic test_ordering();
    repeat (3) send_aw(1'b0, 1'b0);
    repeat (2) send_ar();
    repeat (3) send_b(FIXED_OUT_ID);
    repeat (2) send_r(FIXED_OUT_ID, 1'b1);
  endtask

  task automatic test_backpressure();
    repeat (TXN_DEPTH) send_aw(1'b0, 1'b0);
    start_aw(1'b0, 1'b0);
    check_aw_stalled();
    send_b(FIXED_OUT_ID);
    finish_aw();
    repeat (TXN_DEPTH) send_b(FIXED_OUT_ID);
  endtask

  task automatic test_atomic_slots();
    send_aw(1'b1, 1'b0);
    check_eq(32'(last_aw_id), 32'd0, "first atomic slot");
    send_aw(1'b1, 1'b0);
    check_eq(32'(last_aw_id), 32'd1, "second atomic slot");
    start_aw(1'b1, 1'b0);
    check_aw_stalled();
    // Out of order release, slot 1 goes first
    send_b(out_id_t'(1));
    finish_aw();
    check_eq(32'(last_aw_id), 32'd1, "third atomic slot");
    send_b(out_id_t'(0));
    send_b(out_id_t'(1));
  endtask

  task automatic test_atomic_read();
    send_aw(1'b1, 1'b1);
    send_b(out_id_t'(0));
    // Slot 0 still waits for its R data
    send_aw(1'b1, 1'b0);
    check_eq(32'(last_aw_id), 32'd1, "atomic beside pending R");
    send_aw(1'b0, 1'b0);
    start_aw(1'b1, 1'b0);
    check_aw_stalled();
    send_r(out_id_t'(0), 1'b0);
    check_aw_stalled();
    send_r(out_id_t'(0), 1'b1);
    finish_aw();
    check_eq(32'(last_aw_id), 32'd0, "atomic after last R beat");
    send_b(FIXED_OUT_ID);
    send_b(out_id_t'(1));
    send_b(out_id_t'(0));
  endtask

  task automatic test_dn_stall();
    send_aw(1'b1, 1'b0);
    start_aw(1'b1, 1'b0);
    aw_dn_ready_i <= 1'b0;
    @(negedge clk_i);
    check_eq(32'(aw_dn_valid_o), 32'd1, "AW downstream valid while stalled");
    check_eq(32'(aw_ready_o), 32'd0, "AW ready while downstream stalls");
    stall_slot = lowest_free();
    stall_held = 1'b1;
    check_eq(32'(aw_dn_o.id), 32'(stall_slot), "stalled atomic AW downstream ID");
    // Slot 0 frees while the atomic waits, its ID must not move
    send_b(out_id_t'(0));
    @(negedge clk_i);
    check_eq(32'(aw_dn_o.id), 32'(stall_slot), "held atomic AW downstream ID");
    @(posedge clk_i);
    aw_dn_ready_i <= 1'b1;
    finish_aw();
    check_eq(32'(last_aw_id), 32'd1, "atomic slot after downstream stall");
    send_b(out_id_t'(1));
  endtask

  task automatic test_ready_pass();
    @(posedge clk_i);
    b_ready_i     <= 1'b0;
    r_ready_i     <= 1'b0;
    ar_dn_ready_i <= 1'b0;
    @(negedge clk_i);
    check_eq(32'(b_dn_ready_o), 32'd0, "B downstream ready with upstream ready low");
    check_eq(32'(r_dn_ready_o), 32'd0, "R downstream ready with upstream ready low");
    check_eq(32'(ar_ready_o), 32'd0, "AR ready with downstream ready low");
    @(posedge clk_i);
    b_ready_i     <= 1'b1;
    r_ready_i     <= 1'b1;
    ar_dn_ready_i <= 1'b1;
  endtask

  initial begin
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    aw_i          = '0;
    aw_valid_i    = 1'b0;
    aw_node_i     = '0;
    ar_i          = '0;
    ar_valid_i    = 1'b0;
    ar_node_i     = '0;
    b_ready_i     = 1'b1;
    r_ready_i     = 1'b1;
    aw_dn_ready_i = 1'b1;
    ar_dn_ready_i = 1'b1;
    b_dn_i        = '0;
    b_dn_valid_i  = 1'b0;
    r_dn_i        = '0;
    r_dn_valid_i  = 1'b0;
    slot_b_busy   = '0;
    slot_r_busy   = '0;
    last_aw_id    = '0;
    stall_slot    = '0;
    stall_held    = 1'b0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    // Idle inputs give idle outputs
    @(negedge clk_i);
    check_eq(32'(aw_dn_valid_o), 32'd0, "AW downstream valid after reset");
    check_eq(32'(ar_dn_valid_o), 32'd0, "AR downstream valid after reset");
    check_eq(32'(b_valid_o), 32'd0, "B valid after reset");
    check_eq(32'(r_valid_o), 32'd0, "R valid after reset");
    test_read_remap();
    test_ordering();
    test_backpressure();
    test_atomic_slots();
    test_atomic_read();
    test_dn_stall();
    test_ready_pass();
    $display("Test OK");
    $finish;
  end

endmodule
